// ==== fw_loader.f ====
source/fw_loader_pkg.sv
source/fw_crc32.sv
source/fw_word_writer.sv
source/fw_response_tx.sv
source/fw_upload_ctrl.sv
source/fw_loader.sv
verif/tb_fw_loader.sv

// ==== Bender.yml ====
package:
  name: fw_loader

sources:
  - source/fw_loader_pkg.sv
  - source/fw_crc32.sv
  - source/fw_word_writer.sv
  - source/fw_response_tx.sv
  - source/fw_upload_ctrl.sv
  - source/fw_loader.sv
  - target: simulation
    files:
      - verif/tb_fw_loader.sv

// ==== verif/tb_fw_loader.sv ====
// Testbench of the firmware upload receiver
// Receive buffer, SRAM and UART models, an upload table applied in a loop,
// typed compare tasks and a cycle timeout

`timescale 1ns/100ps

module tb_fw_loader;

    localparam fw_loader_pkg::size_t max_bytes = 32'h0008_0000;
    localparam int chunk_bytes = 64;
    // Reflected CRC-32 polynomial
    localparam logic [31:0] crc32_poly = 32'hEDB88320;

    logic                       clk;
    logic                       resetn;
    logic                       start;
    logic                       busy;
    logic                       done;
    logic                       error;
    fw_loader_pkg::nak_reason_t nak_reason;
    fw_loader_pkg::byte_t       buffer_rd_data;
    logic                       buffer_rd_en;
    logic                       buffer_empty;
    fw_loader_pkg::byte_t       uart_tx_data;
    logic                       uart_tx_valid;
    logic                       uart_tx_ready;
    logic                       sram_valid;
    logic                       sram_we;
    logic                       sram_ready;
    fw_loader_pkg::sram_addr_t  sram_addr_16;
    fw_loader_pkg::word_t       sram_wdata_16;
    logic                       cpu_reset;

    // Model contents
    fw_loader_pkg::byte_t      rx_q[$];
    fw_loader_pkg::byte_t      uart_q[$];
    fw_loader_pkg::sram_addr_t wr_addr[$];
    fw_loader_pkg::word_t      wr_data[$];

    // Upload table with one entry per row in each queue
    string                      row_name[$];
    fw_loader_pkg::size_t       row_size[$];
    fw_loader_pkg::byte_t       row_seed[$];
    logic                       row_corrupt[$];
    logic                       row_pass[$];
    fw_loader_pkg::nak_reason_t row_nak[$];

    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    fw_loader #(
        .max_bytes   (max_bytes),
        .chunk_bytes (chunk_bytes)
    ) i_fw_loader (
        .clk            (clk),
        .resetn         (resetn),
        .start          (start),
        .busy           (busy),
        .done           (done),
        .error          (error),
        .nak_reason     (nak_reason),
        .buffer_rd_data (buffer_rd_data),
        .buffer_rd_en   (buffer_rd_en),
        .buffer_empty   (buffer_empty),
        .uart_tx_data   (uart_tx_data),
        .uart_tx_valid  (uart_tx_valid),
        .uart_tx_ready  (uart_tx_ready),
        .sram_valid     (sram_valid),
        .sram_we        (sram_we),
        .sram_ready     (sram_ready),
        .sram_addr_16   (sram_addr_16),
        .sram_wdata_16  (sram_wdata_16),
        .cpu_reset      (cpu_reset)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ==============================
    // Failure reporting and compares
    // ==============================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string what, input fw_loader_pkg::byte_t expected,
                              input fw_loader_pkg::byte_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
                               what, expected, actual));
        end
    endtask

    task automatic check_word(input string what, input fw_loader_pkg::word_t expected,
                              input fw_loader_pkg::word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
                               what, expected, actual));
        end
    endtask

    task automatic check_addr(input string what, input fw_loader_pkg::sram_addr_t expected,
                              input fw_loader_pkg::sram_addr_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
                               what, expected, actual));
        end
    endtask

    task automatic check_nak(input string what, input fw_loader_pkg::nak_reason_t expected,
                             input fw_loader_pkg::nak_reason_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
                               what, expected, actual));
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected %b, actual %b",
                               what, expected, actual));
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
                               what, expected, actual));
        end
    endtask

    // ==============================
    // Bus models
    // ==============================
    // Byte appears on the falling edge after the read pulse
    always @(negedge clk) begin
        if (buffer_rd_en && rx_q.size() == 0) begin
            fail_run("The DUT read from the receive buffer while it was empty");
        end else begin
            if (buffer_rd_en) begin
                buffer_rd_data = rx_q.pop_front();
            end
            buffer_empty = (rx_q.size() == 0);
        end
    end

    // New ready and the held request meet at the next rising edge
    always @(negedge clk) begin
        sram_ready = ($urandom % 4) != 0;
        if (sram_valid && sram_ready && !sram_we) begin
            fail_run("An SRAM access was taken with sram_we low");
        end else if (sram_valid && sram_ready) begin
            wr_addr.push_back(sram_addr_16);
            wr_data.push_back(sram_wdata_16);
        end
    end

    always @(negedge clk) begin
        uart_tx_ready = ($urandom % 3) != 0;
        if (uart_tx_valid && uart_tx_ready) begin
            uart_q.push_back(uart_tx_data);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles, the upload never finished", cycle_count));
        end
    end

    // ==============================
    // Reference model
    // ==============================
    function automatic fw_loader_pkg::byte_t data_byte(input fw_loader_pkg::byte_t seed,
                                                       input int idx);
        return fw_loader_pkg::byte_t'((idx * 37) ^ (idx >> 7)) ^ seed;
    endfunction

    // Standard reflected CRC-32 with all ones start and inverted result
    function automatic logic [31:0] crc32_ref(input fw_loader_pkg::byte_t bytes[$]);
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        foreach (bytes[i]) begin
            crc = crc ^ {24'd0, bytes[i]};
            repeat (8) begin
                crc = (crc >> 1) ^ (crc32_poly & {32{crc[0]}});
            end
        end
        return ~crc;
    endfunction

    // ACK letters run A to Z and wrap
    function automatic fw_loader_pkg::byte_t ack_letter(input int n);
        return fw_loader_pkg::char_ack_base + fw_loader_pkg::byte_t'(n % 26);
    endfunction

    task automatic add_row(input string name, input fw_loader_pkg::size_t pkt_size,
                           input fw_loader_pkg::byte_t seed, input logic corrupt,
                           input logic pass, input fw_loader_pkg::nak_reason_t nak);
        row_name.push_back(name);
        row_size.push_back(pkt_size);
        row_seed.push_back(seed);
        row_corrupt.push_back(corrupt);
        row_pass.push_back(pass);
        row_nak.push_back(nak);
    endtask

    // ==============================
    // One upload
    // ==============================
    task automatic run_upload(input int r);
        fw_loader_pkg::byte_t data_q[$];
        fw_loader_pkg::byte_t exp_q[$];
        fw_loader_pkg::size_t pkt_size;
        fw_loader_pkg::byte_t hi_byte;
        logic                 accepted;
        logic [31:0]          crc;
        int                   n_acks;
        int                   n_words;
        string                name;

        name     = row_name[r];
        pkt_size = row_size[r];
        accepted = (pkt_size != 0) && (pkt_size <= max_bytes);
        uart_q.delete();
        wr_addr.delete();
        wr_data.delete();

        // Ready command and little-endian size
        rx_q.push_back(fw_loader_pkg::char_ready);
        for (int i = 0; i < 4; i++) begin
            rx_q.push_back(pkt_size[8*i +: 8]);
        end
        if (accepted) begin
            for (int i = 0; i < pkt_size; i++) begin
                data_q.push_back(data_byte(row_seed[r], i));
                rx_q.push_back(data_q[i]);
            end
            crc = crc32_ref(data_q);
            if (row_corrupt[r]) begin
                crc = crc ^ 32'h0000_0100;
            end
            rx_q.push_back(fw_loader_pkg::char_crc_cmd);
            for (int i = 0; i < 4; i++) begin
                rx_q.push_back(crc[8*i +: 8]);
            end
        end

        // Expected responses to ready, size, chunks, last word and CRC
        exp_q.push_back(ack_letter(0));
        n_acks = 1;
        if (!accepted) begin
            exp_q.push_back(fw_loader_pkg::char_nak);
        end else begin
            for (int k = 0; k < 2 + (pkt_size - 1) / chunk_bytes; k++) begin
                exp_q.push_back(ack_letter(n_acks));
                n_acks++;
            end
            exp_q.push_back(row_corrupt[r] ? fw_loader_pkg::char_nak : ack_letter(n_acks));
        end

        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag({name, " busy after start"}, 1'b1, busy);
        while (!(done || error)) begin
            @(negedge clk);
        end

        check_flag({name, " done"}, row_pass[r], done);
        check_flag({name, " error"}, !row_pass[r], error);
        check_flag({name, " busy at end"}, 1'b0, busy);
        check_flag({name, " cpu_reset"}, !row_pass[r], cpu_reset);
        check_nak({name, " nak_reason"}, row_nak[r], nak_reason);

        check_count({name, " UART byte count"}, exp_q.size(), uart_q.size());
        foreach (exp_q[i]) begin
            check_byte($sformatf("%s UART byte %0d", name, i), exp_q[i], uart_q[i]);
        end

        n_words = accepted ? (pkt_size + 1) / 2 : 0;
        check_count({name, " SRAM write count"}, n_words, wr_data.size());
        for (int w = 0; w < n_words; w++) begin
            hi_byte = (2 * w + 1 < pkt_size) ? data_q[2*w+1] : 8'h00;
            check_addr($sformatf("%s SRAM address %0d", name, w),
                       fw_loader_pkg::sram_addr_t'(w), wr_addr[w]);
            check_word($sformatf("%s SRAM word %0d", name, w), {hi_byte, data_q[2*w]},
                       wr_data[w]);
        end

        if (rx_q.size() != 0) begin
            fail_run({name, ": bytes were left unread in the receive buffer"});
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int unsigned data_total;

        resetn         = 1'b0;
        start          = 1'b0;
        buffer_rd_data = 8'h00;
        buffer_empty   = 1'b1;
        uart_tx_ready  = 1'b0;
        sram_ready     = 1'b0;
        void'($urandom(32'h64f5));

        add_row("good_7", 32'd7, 8'h11, 1'b0, 1'b1, 8'h00);
        add_row("size_zero", 32'd0, 8'h00, 1'b0, 1'b0, 8'h02);
        add_row("size_too_large", max_bytes + 32'd1, 8'h00, 1'b0, 1'b0, 8'h01);
        add_row("crc_mismatch_40", 32'd40, 8'h5a, 1'b1, 1'b0, 8'h03);
        add_row("good_1600", 32'd1600, 8'h3c, 1'b0, 1'b1, 8'h00);
        add_row("crc_mismatch_130", 32'd130, 8'hc3, 1'b1, 1'b0, 8'h03);
        add_row("good_after_fail", 32'd9, 8'h77, 1'b0, 1'b1, 8'h00);

        // Only accepted sizes carry data bytes
        data_total = 0;
        foreach (row_size[r]) begin
            if (row_size[r] != 0 && row_size[r] <= max_bytes) begin
                data_total += row_size[r];
            end
        end
        cycle_limit = 200 * data_total + 2000 * row_name.size();

        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        check_flag("reset busy", 1'b0, busy);
        check_flag("reset done", 1'b0, done);
        check_flag("reset error", 1'b0, error);
        check_flag("reset buffer_rd_en", 1'b0, buffer_rd_en);
        check_flag("reset sram_valid", 1'b0, sram_valid);
        check_flag("reset sram_we", 1'b0, sram_we);
        check_flag("reset uart_tx_valid", 1'b0, uart_tx_valid);
        check_flag("reset cpu_reset", 1'b1, cpu_reset);
        check_nak("reset nak_reason", 8'h00, nak_reason);

        for (int r = 0; r < row_name.size(); r++) begin
            run_upload(r);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== source/fw_loader.sv ====
// Firmware upload receiver, top level
// Controller, SRAM word writer, CRC-32 unit and response transmitter

`timescale 1ns/100ps

module fw_loader #(
    parameter fw_loader_pkg::size_t max_bytes = 32'h0008_0000,
    parameter int chunk_bytes = 64
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    output logic                       busy,
    output logic                       done,
    output logic                       error,
    output fw_loader_pkg::nak_reason_t nak_reason,
    input  fw_loader_pkg::byte_t       buffer_rd_data,
    output logic                       buffer_rd_en,
    input  logic                       buffer_empty,
    output fw_loader_pkg::byte_t       uart_tx_data,
    output logic                       uart_tx_valid,
    input  logic                       uart_tx_ready,
    output logic                       sram_valid,
    output logic                       sram_we,
    input  logic                       sram_ready,
    output fw_loader_pkg::sram_addr_t  sram_addr_16,
    output fw_loader_pkg::word_t       sram_wdata_16,
    output logic                       cpu_reset
);

    logic                 session_start;
    logic                 data_valid;
    logic                 last_byte;
    fw_loader_pkg::byte_t rx_byte;
    logic                 word_done;
    fw_loader_pkg::crc_t  crc_value;
    logic                 resp_ack;
    logic                 resp_nak;
    logic                 resp_busy;

    // ==============================
    // Decode
    // ==============================
    fw_upload_ctrl #(
        .max_bytes   (max_bytes),
        .chunk_bytes (chunk_bytes)
    ) i_fw_upload_ctrl (
        .clk            (clk),
        .resetn         (resetn),
        .start          (start),
        .buffer_rd_data (buffer_rd_data),
        .buffer_empty   (buffer_empty),
        .buffer_rd_en   (buffer_rd_en),
        .busy           (busy),
        .done           (done),
        .error          (error),
        .cpu_reset      (cpu_reset),
        .nak_reason     (nak_reason),
        .session_start  (session_start),
        .data_valid     (data_valid),
        .last_byte      (last_byte),
        .rx_byte        (rx_byte),
        .word_done      (word_done),
        .crc_value      (crc_value),
        .resp_ack       (resp_ack),
        .resp_nak       (resp_nak),
        .resp_busy      (resp_busy)
    );

    // ==============================
    // Execute
    // ==============================
    fw_word_writer i_fw_word_writer (
        .clk           (clk),
        .resetn        (resetn),
        .session_start (session_start),
        .data_valid    (data_valid),
        .last_byte     (last_byte),
        .rx_byte       (rx_byte),
        .sram_ready    (sram_ready),
        .sram_valid    (sram_valid),
        .sram_we       (sram_we),
        .sram_addr_16  (sram_addr_16),
        .sram_wdata_16 (sram_wdata_16),
        .word_done     (word_done)
    );

    fw_crc32 i_fw_crc32 (
        .clk           (clk),
        .resetn        (resetn),
        .session_start (session_start),
        .data_valid    (data_valid),
        .rx_byte       (rx_byte),
        .crc_value     (crc_value)
    );

    // ==============================
    // Result
    // ==============================
    fw_response_tx i_fw_response_tx (
        .clk           (clk),
        .resetn        (resetn),
        .session_start (session_start),
        .resp_ack      (resp_ack),
        .resp_nak      (resp_nak),
        .resp_busy     (resp_busy),
        .uart_tx_data  (uart_tx_data),
        .uart_tx_valid (uart_tx_valid),
        .uart_tx_ready (uart_tx_ready)
    );

endmodule

// ==== source/fw_upload_ctrl.sv ====
// Upload protocol controller
// Two-phase buffer byte fetch, size and CRC assembly, chunk accounting
// and the session FSM with its status outputs

`timescale 1ns/100ps

module fw_upload_ctrl #(
    parameter fw_loader_pkg::size_t max_bytes = 32'h0008_0000,
    parameter int chunk_bytes = 64
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    input  fw_loader_pkg::byte_t       buffer_rd_data,
    input  logic                       buffer_empty,
    output logic                       buffer_rd_en,
    output logic                       busy,
    output logic                       done,
    output logic                       error,
    output logic                       cpu_reset,
    output fw_loader_pkg::nak_reason_t nak_reason,
    output logic                       session_start,
    output logic                       data_valid,
    output logic                       last_byte,
    output fw_loader_pkg::byte_t       rx_byte,
    input  logic                       word_done,
    input  fw_loader_pkg::crc_t        crc_value,
    output logic                       resp_ack,
    output logic                       resp_nak,
    input  logic                       resp_busy
);

    localparam int chunk_w = $clog2(chunk_bytes + 1);

    fw_loader_pkg::ctrl_state_t state;
    fw_loader_pkg::ctrl_state_t next_state;
    fw_loader_pkg::size_t       packet_size;
    fw_loader_pkg::size_t       bytes_received;
    fw_loader_pkg::crc_t        expected_crc;
    logic [chunk_w-1:0]         chunk_count;
    logic [1:0]                 byte_idx;
    logic                       rd_wait;
    logic                       byte_valid;
    logic                       fetch_active;

    // ==============================
    // Buffer byte fetch
    // ==============================
    assign fetch_active = (state == fw_loader_pkg::wait_ready) ||
                          (state == fw_loader_pkg::recv_size) ||
                          (state == fw_loader_pkg::recv_data) ||
                          (state == fw_loader_pkg::recv_crc_cmd) ||
                          (state == fw_loader_pkg::recv_crc);

    // One read in flight at a time, a new one only after its byte is consumed
    always_ff @(posedge clk) begin
        if (!resetn) begin
            buffer_rd_en <= 1'b0;
            rd_wait      <= 1'b0;
            byte_valid   <= 1'b0;
        end else begin
            buffer_rd_en <= fetch_active && !buffer_empty &&
                            !(buffer_rd_en || rd_wait || byte_valid);
            rd_wait      <= buffer_rd_en;
            byte_valid   <= rd_wait;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_wait) begin
            rx_byte <= buffer_rd_data;
        end
    end

    assign data_valid = byte_valid && (state == fw_loader_pkg::recv_data);
    assign last_byte  = (bytes_received == packet_size - 32'd1);

    // ==============================
    // Session FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state         <= fw_loader_pkg::idle;
            next_state    <= fw_loader_pkg::idle;
            busy          <= 1'b0;
            done          <= 1'b0;
            error         <= 1'b0;
            cpu_reset     <= 1'b1;
            nak_reason    <= fw_loader_pkg::nak_none;
            session_start <= 1'b0;
            resp_ack      <= 1'b0;
            resp_nak      <= 1'b0;
        end else begin
            done          <= 1'b0;
            error         <= 1'b0;
            session_start <= 1'b0;
            resp_ack      <= 1'b0;
            resp_nak      <= 1'b0;

            case (state)
                fw_loader_pkg::idle: begin
                    if (start) begin
                        busy           <= 1'b1;
                        cpu_reset      <= 1'b1;
                        nak_reason     <= fw_loader_pkg::nak_none;
                        session_start  <= 1'b1;
                        bytes_received <= '0;
                        state          <= fw_loader_pkg::wait_ready;
                    end
                end

                fw_loader_pkg::wait_ready: begin
                    if (byte_valid && rx_byte == fw_loader_pkg::char_ready) begin
                        resp_ack   <= 1'b1;
                        byte_idx   <= 2'd0;
                        next_state <= fw_loader_pkg::recv_size;
                        state      <= fw_loader_pkg::send_resp;
                    end
                end

                // Little-endian, first byte ends up in bits 7:0
                fw_loader_pkg::recv_size: begin
                    if (byte_valid) begin
                        packet_size <= {rx_byte, packet_size[31:8]};
                        byte_idx    <= byte_idx + 2'd1;
                        if (byte_idx == 2'd3) begin
                            state <= fw_loader_pkg::check_size;
                        end
                    end
                end

                fw_loader_pkg::check_size: begin
                    if (packet_size == '0) begin
                        resp_nak   <= 1'b1;
                        nak_reason <= fw_loader_pkg::nak_size_zero;
                        next_state <= fw_loader_pkg::error;
                    end else if (packet_size > max_bytes) begin
                        resp_nak   <= 1'b1;
                        nak_reason <= fw_loader_pkg::nak_size_too_large;
                        next_state <= fw_loader_pkg::error;
                    end else begin
                        resp_ack    <= 1'b1;
                        chunk_count <= '0;
                        next_state  <= fw_loader_pkg::recv_data;
                    end
                    state <= fw_loader_pkg::send_resp;
                end

                fw_loader_pkg::recv_data: begin
                    if (byte_valid) begin
                        bytes_received <= bytes_received + 32'd1;
                        chunk_count    <= chunk_count + 1'b1;
                        // Second byte of a word or the final byte starts a write
                        if (bytes_received[0] || last_byte) begin
                            state <= fw_loader_pkg::store_word;
                        end
                    end
                end

                // Fetch stalls here until the SRAM takes the word
                fw_loader_pkg::store_word: begin
                    if (word_done) begin
                        if (bytes_received == packet_size) begin
                            resp_ack   <= 1'b1;
                            next_state <= fw_loader_pkg::recv_crc_cmd;
                            state      <= fw_loader_pkg::send_resp;
                        end else if (chunk_count >= chunk_bytes) begin
                            resp_ack    <= 1'b1;
                            chunk_count <= '0;
                            next_state  <= fw_loader_pkg::recv_data;
                            state       <= fw_loader_pkg::send_resp;
                        end else begin
                            state <= fw_loader_pkg::recv_data;
                        end
                    end
                end

                fw_loader_pkg::recv_crc_cmd: begin
                    if (byte_valid && rx_byte == fw_loader_pkg::char_crc_cmd) begin
                        byte_idx <= 2'd0;
                        state    <= fw_loader_pkg::recv_crc;
                    end
                end

                fw_loader_pkg::recv_crc: begin
                    if (byte_valid) begin
                        expected_crc <= {rx_byte, expected_crc[31:8]};
                        byte_idx     <= byte_idx + 2'd1;
                        if (byte_idx == 2'd3) begin
                            state <= fw_loader_pkg::verify_crc;
                        end
                    end
                end

                fw_loader_pkg::verify_crc: begin
                    if (crc_value == expected_crc) begin
                        resp_ack   <= 1'b1;
                        next_state <= fw_loader_pkg::complete;
                    end else begin
                        resp_nak   <= 1'b1;
                        nak_reason <= fw_loader_pkg::nak_crc_mismatch;
                        next_state <= fw_loader_pkg::error;
                    end
                    state <= fw_loader_pkg::send_resp;
                end

                // resp_busy covers the request cycle as well
                fw_loader_pkg::send_resp: begin
                    if (!resp_busy) begin
                        state <= next_state;
                    end
                end

                fw_loader_pkg::complete: begin
                    done      <= 1'b1;
                    busy      <= 1'b0;
                    cpu_reset <= 1'b0;
                    state     <= fw_loader_pkg::idle;
                end

                fw_loader_pkg::error: begin
                    error     <= 1'b1;
                    busy      <= 1'b0;
                    cpu_reset <= 1'b1;
                    state     <= fw_loader_pkg::idle;
                end

                default: begin
                    state <= fw_loader_pkg::idle;
                end
            endcase
        end
    end

endmodule

// ==== source/fw_response_tx.sv ====
// Response transmitter
// Rotating ACK letters, NAK character and the UART valid/ready hold

`timescale 1ns/100ps

module fw_response_tx (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 session_start,
    input  logic                 resp_ack,
    input  logic                 resp_nak,
    output logic                 resp_busy,
    output fw_loader_pkg::byte_t uart_tx_data,
    output logic                 uart_tx_valid,
    input  logic                 uart_tx_ready
);

    // Offset from 'A', wraps after 'Z'
    fw_loader_pkg::byte_t ack_idx;

    assign resp_busy = resp_ack || resp_nak || uart_tx_valid;

    always_ff @(posedge clk) begin
        if (resp_ack) begin
            uart_tx_data <= fw_loader_pkg::char_ack_base + ack_idx;
        end else if (resp_nak) begin
            uart_tx_data <= fw_loader_pkg::char_nak;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack_idx       <= '0;
            uart_tx_valid <= 1'b0;
        end else begin
            if (session_start) begin
                ack_idx <= '0;
            end else if (resp_ack) begin
                ack_idx <= (ack_idx == fw_loader_pkg::ack_letters - 8'd1) ?
                           8'd0 : ack_idx + 8'd1;
            end

            if (resp_ack || resp_nak) begin
                uart_tx_valid <= 1'b1;
            end else if (uart_tx_ready) begin
                uart_tx_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== source/fw_word_writer.sv ====
// SRAM word writer
// Packs data bytes into 16-bit words and holds each write until accepted

`timescale 1ns/100ps

module fw_word_writer (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      session_start,
    input  logic                      data_valid,
    input  logic                      last_byte,
    input  fw_loader_pkg::byte_t      rx_byte,
    input  logic                      sram_ready,
    output logic                      sram_valid,
    output logic                      sram_we,
    output fw_loader_pkg::sram_addr_t sram_addr_16,
    output fw_loader_pkg::word_t      sram_wdata_16,
    output logic                      word_done
);

    fw_loader_pkg::byte_t low_byte;
    logic                 have_low;

    assign word_done = sram_valid && sram_ready;

    // Low byte holding
    always_ff @(posedge clk) begin
        if (data_valid && !have_low) begin
            low_byte <= rx_byte;
        end
    end

    // Odd final byte goes out with a zero high byte
    always_ff @(posedge clk) begin
        if (data_valid && (have_low || last_byte)) begin
            sram_wdata_16 <= have_low ? {rx_byte, low_byte} : {8'h00, rx_byte};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            have_low     <= 1'b0;
            sram_valid   <= 1'b0;
            sram_we      <= 1'b0;
            sram_addr_16 <= '0;
        end else if (session_start) begin
            have_low     <= 1'b0;
            sram_addr_16 <= '0;
        end else begin
            if (data_valid) begin
                if (have_low || last_byte) begin
                    have_low   <= 1'b0;
                    sram_valid <= 1'b1;
                    sram_we    <= 1'b1;
                end else begin
                    have_low <= 1'b1;
                end
            end
            if (word_done) begin
                sram_valid   <= 1'b0;
                sram_we      <= 1'b0;
                sram_addr_16 <= sram_addr_16 + 19'd1;
            end
        end
    end

endmodule

// ==== source/fw_crc32.sv ====
// Byte-serial reflected CRC-32 over the upload data

`timescale 1ns/100ps

module fw_crc32 (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 session_start,
    input  logic                 data_valid,
    input  fw_loader_pkg::byte_t rx_byte,
    output fw_loader_pkg::crc_t  crc_value
);

    fw_loader_pkg::crc_t crc_reg;
    fw_loader_pkg::crc_t crc_next;

    // Eight shift steps, LSB first
    always_comb begin
        crc_next = crc_reg ^ {24'h000000, rx_byte};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ fw_loader_pkg::crc_poly;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || session_start) begin
            crc_reg <= fw_loader_pkg::crc_init;
        end else if (data_valid) begin
            crc_reg <= crc_next;
        end
    end

    // Final inversion
    assign crc_value = ~crc_reg;

endmodule

// ==== source/fw_loader_pkg.sv ====
// Shared definitions of the firmware upload receiver
// Widths, protocol characters, NAK codes, CRC constants and controller states

package fw_loader_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [18:0] sram_addr_t;
    typedef logic [31:0] size_t;
    typedef logic [31:0] crc_t;
    typedef logic [7:0]  nak_reason_t;

    // Protocol characters
    localparam byte_t char_ready    = 8'h52;
    localparam byte_t char_crc_cmd  = 8'h43;
    localparam byte_t char_nak      = 8'h4E;
    localparam byte_t char_ack_base = 8'h41;
    localparam byte_t ack_letters   = 8'd26;

    // NAK reasons
    localparam nak_reason_t nak_none           = 8'h00;
    localparam nak_reason_t nak_size_too_large = 8'h01;
    localparam nak_reason_t nak_size_zero      = 8'h02;
    localparam nak_reason_t nak_crc_mismatch   = 8'h03;

    // Reflected CRC-32
    localparam crc_t crc_poly = 32'hEDB88320;
    localparam crc_t crc_init = 32'hFFFFFFFF;

    typedef enum logic [3:0] {
        idle, wait_ready, recv_size, check_size,
        recv_data, store_word, recv_crc_cmd, recv_crc,
        verify_crc, send_resp, complete, error
    } ctrl_state_t;

endpackage
